//--- src/memAccess_macros.svh
`ifndef MEM_ACCESS_MACROS_SVH
`define MEM_ACCESS_MACROS_SVH

// Access width codes carried in widthCtrl
`define memWidth1 2'b00
`define memWidth2 2'b01
`define memWidth4 2'b10

// Word-address bits of the data memory
`define MEM_ADDR_BITS 8

`define MEM_WORDS (1 << `MEM_ADDR_BITS)

`endif

//--- src/mipsInstrPkg.sv
`default_nettype none

package mipsInstrPkg;

    // Primary opcodes of the load/store group
    typedef enum logic [5:0] {
        opLb  = 6'h20,
        opLh  = 6'h21,
        opLwl = 6'h22,
        opLw  = 6'h23,
        opLbu = 6'h24,
        opLhu = 6'h25,
        opLwr = 6'h26,
        opSb  = 6'h28,
        opSh  = 6'h29,
        opSwl = 6'h2a,
        opSw  = 6'h2b,
        opSwr = 6'h2e
    } opcode_e;

    // The opcode field stays raw bits so that any encoding can be carried
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeInstr_t;

    function automatic logic [31:0] signExtendImm(input logic [15:0] imm);
        signExtendImm = {{16{imm[15]}}, imm};
    endfunction

endpackage

`default_nettype wire

//--- src/memOpPkg.sv
`default_nettype none

package memOpPkg;

    // One decoded access, valid for the cycle it is presented in
    typedef struct packed {
        logic        isLoad;
        logic        isStore;
        logic [1:0]  widthCtrl;
        logic        extendCtrl;   // Sign extend narrow loads
        logic        unaligned;    // LWL, LWR, SWL or SWR
        logic        leftPart;     // Left half of an unaligned pair
        logic [31:0] address;
    } memOp_t;

    // What the result stage needs once the memory word comes back
    typedef struct packed {
        logic [1:0]  widthCtrl;
        logic        extendCtrl;
        logic        unaligned;
        logic        leftPart;
        logic [1:0]  offset;
        logic [31:0] originalData; // Old rt value for the LWL/LWR merge
    } loadStage_t;

    function automatic loadStage_t toLoadStage(input memOp_t op, input logic [31:0] rtData);
        loadStage_t stage;
        stage.widthCtrl    = op.widthCtrl;
        stage.extendCtrl   = op.extendCtrl;
        stage.unaligned    = op.unaligned;
        stage.leftPart     = op.leftPart;
        stage.offset       = op.address[1:0];
        stage.originalData = rtData;
        return stage;
    endfunction

endpackage

`default_nettype wire

//--- src/MemInstrDecoder.sv
`timescale 1ns/1ps
`include "memAccess_macros.svh"
`default_nettype none

module MemInstrDecoder (
    input  mipsInstrPkg::iTypeInstr_t instr,
    input  logic [31:0]               baseValue,
    input  logic                      reqValid,
    output memOpPkg::memOp_t          memOp
);
    import mipsInstrPkg::*;
    import memOpPkg::*;

    logic loadOp;
    logic storeOp;

    always_comb begin
        loadOp            = 1'b0;
        storeOp           = 1'b0;
        memOp             = '0;
        memOp.widthCtrl   = `memWidth4;
        memOp.address     = baseValue + signExtendImm(instr.imm);

        case (instr.opcode)
            opLb: begin
                loadOp           = 1'b1;
                memOp.widthCtrl  = `memWidth1;
                memOp.extendCtrl = 1'b1;
            end
            opLbu: begin
                loadOp          = 1'b1;
                memOp.widthCtrl = `memWidth1;
            end
            opLh: begin
                loadOp           = 1'b1;
                memOp.widthCtrl  = `memWidth2;
                memOp.extendCtrl = 1'b1;
            end
            opLhu: begin
                loadOp          = 1'b1;
                memOp.widthCtrl = `memWidth2;
            end
            opLw: loadOp = 1'b1;
            opLwl: begin
                loadOp          = 1'b1;
                memOp.unaligned = 1'b1;
                memOp.leftPart  = 1'b1;
            end
            opLwr: begin
                loadOp          = 1'b1;
                memOp.unaligned = 1'b1;
            end
            opSb: begin
                storeOp         = 1'b1;
                memOp.widthCtrl = `memWidth1;
            end
            opSh: begin
                storeOp         = 1'b1;
                memOp.widthCtrl = `memWidth2;
            end
            opSw: storeOp = 1'b1;
            opSwl: begin
                storeOp         = 1'b1;
                memOp.unaligned = 1'b1;
                memOp.leftPart  = 1'b1;
            end
            opSwr: begin
                storeOp         = 1'b1;
                memOp.unaligned = 1'b1;
            end
            default: ; // Anything else makes no access
        endcase

        memOp.isLoad  = reqValid & loadOp;
        memOp.isStore = reqValid & storeOp;
    end

endmodule

`default_nettype wire

//--- src/DataMemoryWriteShifter.sv
`timescale 1ns/1ps
`include "memAccess_macros.svh"
`default_nettype none

module DataMemoryWriteShifter (
    input  memOpPkg::memOp_t memOp,
    input  logic [31:0]      writeDataIn,
    output logic [31:0]      writeDataOut,
    output logic [3:0]       writeByteEn
);
    import memOpPkg::*;

    logic [1:0] offset;

    assign offset = memOp.address[1:0];

    always_comb begin
        writeDataOut = '0;
        writeByteEn  = '0;
        if (memOp.unaligned) begin
            if (memOp.leftPart) begin // SWL puts the top bytes of rt at the low end
                writeDataOut = writeDataIn >> {~offset, 3'b000};
                writeByteEn  = 4'b1111 >> ~offset;
            end else begin
                writeDataOut = writeDataIn << {offset, 3'b000};
                writeByteEn  = 4'b1111 << offset;
            end
        end else begin
            case (memOp.widthCtrl)
                `memWidth4: begin
                    writeDataOut = writeDataIn;
                    writeByteEn  = 4'b1111;
                end
                `memWidth2: begin
                    writeDataOut = {16'b0, writeDataIn[15:0]} << {offset, 3'b000};
                    writeByteEn  = 4'b0011 << offset;
                end
                `memWidth1: begin
                    writeDataOut = {24'b0, writeDataIn[7:0]} << {offset, 3'b000};
                    writeByteEn  = 4'b0001 << offset;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/DataMemory.sv
`timescale 1ns/1ps
`include "memAccess_macros.svh"
`default_nettype none

module DataMemory (
    input  logic             clk,
    input  memOpPkg::memOp_t memOp,
    input  logic [31:0]      writeData,
    input  logic [3:0]       writeByteEn,
    output logic [31:0]      readWord
);
    import memOpPkg::*;

    // Byte lanes packed per word so each enable maps to one lane
    logic [3:0][7:0] memArray [`MEM_WORDS];

    logic [`MEM_ADDR_BITS-1:0] wordAddr;

    assign wordAddr = memOp.address[`MEM_ADDR_BITS+1:2]; // Upper address bits wrap around

    always_ff @(posedge clk) begin
        if (memOp.isStore) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (writeByteEn[lane]) begin
                    memArray[wordAddr][lane] <= writeData[lane*8 +: 8];
                end
            end
        end
    end

    // Read port holds its value between loads
    always_ff @(posedge clk) begin
        if (memOp.isLoad) begin
            readWord <= memArray[wordAddr];
        end
    end

endmodule

`default_nettype wire

//--- src/DataMemoryReadShifter.sv
`timescale 1ns/1ps
`include "memAccess_macros.svh"
`default_nettype none

module DataMemoryReadShifter (
    input  logic             clk,
    input  logic             rst,
    input  memOpPkg::memOp_t memOp,
    input  logic [31:0]      originalData,
    input  logic [31:0]      readWord,
    output logic             loadValid,
    output logic [31:0]      loadData
);
    import memOpPkg::*;

    loadStage_t loadStage;
    logic [15:0] halfWord;
    logic [7:0]  readByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            loadValid <= 1'b0;
        end else begin
            loadValid <= memOp.isLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (memOp.isLoad) begin
            loadStage <= toLoadStage(memOp, originalData);
        end
    end

    assign halfWord = loadStage.offset[1] ? readWord[31:16] : readWord[15:0];
    assign readByte = readWord[loadStage.offset*8 +: 8];

    always_comb begin
        loadData = '0;
        if (loadStage.unaligned) begin
            if (loadStage.leftPart) begin // LWL keeps the low rt bytes the word does not cover
                loadData = (readWord << {~loadStage.offset, 3'b000})
                         | (loadStage.originalData
                            & ~(32'hFFFF_FFFF << {~loadStage.offset, 3'b000}));
            end else begin
                loadData = (readWord >> {loadStage.offset, 3'b000})
                         | (loadStage.originalData
                            & ~(32'hFFFF_FFFF >> {loadStage.offset, 3'b000}));
            end
        end else begin
            case (loadStage.widthCtrl)
                `memWidth4: loadData = readWord;
                `memWidth2: loadData = {{16{halfWord[15] & loadStage.extendCtrl}}, halfWord};
                `memWidth1: loadData = {{24{readByte[7] & loadStage.extendCtrl}}, readByte};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/MemAccessUnit.sv
`timescale 1ns/1ps
`default_nettype none

module MemAccessUnit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,
    input  mipsInstrPkg::iTypeInstr_t instr,
    input  logic [31:0]               baseValue,
    input  logic [31:0]               rtValue,
    input  logic [31:0]               storeValue,
    output logic                      loadValid,
    output logic [31:0]               loadData
);
    import memOpPkg::*;

    memOp_t      memOp;
    logic [31:0] writeData;
    logic [3:0]  writeByteEn;
    logic [31:0] readWord;

    MemInstrDecoder decoder (
        .instr     (instr),
        .baseValue (baseValue),
        .reqValid  (reqValid),
        .memOp     (memOp)
    );

    DataMemoryWriteShifter writeShifter (
        .memOp        (memOp),
        .writeDataIn  (storeValue),
        .writeDataOut (writeData),
        .writeByteEn  (writeByteEn)
    );

    DataMemory dataMem (
        .clk         (clk),
        .memOp       (memOp),
        .writeData   (writeData),
        .writeByteEn (writeByteEn),
        .readWord    (readWord)
    );

    // The rt value rides along with the load for the LWL/LWR merge
    DataMemoryReadShifter readShifter (
        .clk          (clk),
        .rst          (rst),
        .memOp        (memOp),
        .originalData (rtValue),
        .readWord     (readWord),
        .loadValid    (loadValid),
        .loadData     (loadData)
    );

endmodule

`default_nettype wire

//--- tests/memAccess_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module MemAccessAsserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      reqValid,
    input mipsInstrPkg::iTypeInstr_t instr,
    input logic                      loadValid
);
    import mipsInstrPkg::*;

    logic loadRequest;

    // Only the seven load opcodes start a read
    assign loadRequest = reqValid
                       && (instr.opcode inside {opLb, opLbu, opLh, opLhu, opLw, opLwl, opLwr});

    resetClearsValid: assert property (@(posedge clk) rst |=> !loadValid)
        else $error("loadValid high after a reset cycle");

    validFollowsLoad: assert property (@(posedge clk) disable iff (rst)
        loadValid |-> $past(loadRequest))
        else $error("loadValid high without a load request one cycle earlier");

    validNotHeld: assert property (@(posedge clk) disable iff (rst)
        (loadValid && $past(loadValid)) |-> ($past(loadRequest) && $past(loadRequest, 2)))
        else $error("loadValid held for two cycles without a load request in each");

endmodule

bind MemAccessUnit MemAccessAsserts accessChecks (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .instr     (instr),
    .loadValid (loadValid)
);

`default_nettype wire

//--- tests/MemAccessUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module MemAccessUnitTb;
    import mipsInstrPkg::*;

    localparam int resetCycles = 8;
    localparam int numRandom   = 300;
    localparam int numRequests = 16 + 16 + 4 + 16 + 60 + numRandom + 2;
    localparam int maxCycles   = resetCycles + numRequests + 20;

    logic        clk;
    logic        rst;
    logic        reqValid;
    iTypeInstr_t instr;
    logic [31:0] baseValue;
    logic [31:0] rtValue;
    logic [31:0] storeValue;
    logic        loadValid;
    logic [31:0] loadData;

    logic [7:0]  memModel [64]; // Byte image of the first 16 words
    logic [31:0] expectQ [$];
    logic [31:0] lfsrState;
    logic [5:0]  opcodeTable [16];
    int          cycleCount;

    MemAccessUnit dut (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .instr      (instr),
        .baseValue  (baseValue),
        .rtValue    (rtValue),
        .storeValue (storeValue),
        .loadValid  (loadValid),
        .loadData   (loadData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > maxCycles) begin
                failRun($sformatf("Timeout: the run did not finish within %0d cycles",
                                  maxCycles));
            end
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic isLoadOpcode(input logic [5:0] op);
        return op inside {opLb, opLbu, opLh, opLhu, opLw, opLwl, opLwr};
    endfunction

    function automatic logic isStoreOpcode(input logic [5:0] op);
        return op inside {opSb, opSh, opSw, opSwl, opSwr};
    endfunction

    task automatic applyStore(input logic [5:0] op, input logic [5:0] addr,
                              input logic [31:0] value);
        int wordBase;
        int offset;
        wordBase = int'(addr[5:2]) * 4;
        offset   = int'(addr[1:0]);
        case (op)
            opSw: begin
                for (int k = 0; k < 4; k++) begin
                    memModel[wordBase + k] = value[8*k +: 8];
                end
            end
            opSh: begin
                for (int i = 0; i < 2; i++) begin
                    if (offset + i < 4) begin // Upper byte falls off past lane 3
                        memModel[wordBase + offset + i] = value[8*i +: 8];
                    end
                end
            end
            opSb: memModel[wordBase + offset] = value[7:0];
            opSwl: begin
                // Lanes up to the offset take the top bytes of the value
                for (int k = 0; k <= offset; k++) begin
                    memModel[wordBase + k] = value[8*(k + 3 - offset) +: 8];
                end
            end
            opSwr: begin
                for (int k = offset; k < 4; k++) begin
                    memModel[wordBase + k] = value[8*(k - offset) +: 8];
                end
            end
            default: ;
        endcase
    endtask

    function automatic logic [31:0] expectedLoad(input logic [5:0] op, input logic [5:0] addr,
                                                 input logic [31:0] rt);
        int          wordBase;
        int          offset;
        logic [31:0] word;
        logic [31:0] result;
        wordBase = int'(addr[5:2]) * 4;
        offset   = int'(addr[1:0]);
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8] = memModel[wordBase + k];
        end
        result = rt;
        case (op)
            opLw:  result = word;
            opLb:  result = {{24{word[8*offset + 7]}}, word[8*offset +: 8]};
            opLbu: result = {24'b0, word[8*offset +: 8]};
            opLh:  result = {{16{word[8*offset + 15]}}, word[8*offset +: 16]};
            opLhu: result = {16'b0, word[8*offset +: 16]};
            opLwl: begin
                for (int j = 3 - offset; j < 4; j++) begin // Memory fills from the top byte
                    result[8*j +: 8] = word[8*(j - 3 + offset) +: 8];
                end
            end
            opLwr: begin
                for (int j = 0; j + offset < 4; j++) begin
                    result[8*j +: 8] = word[8*(j + offset) +: 8];
                end
            end
            default: ;
        endcase
        return result;
    endfunction

    task automatic checkOutputs();
        logic [31:0] expected;
        if (expectQ.size() > 0) begin
            expected = expectQ.pop_front();
            assert (loadValid === 1'b1) else
                failRun($sformatf("MISMATCH at %0t ns: loadValid low after a load", $time));
            assert (loadData === expected) else
                failRun($sformatf("MISMATCH at %0t ns: loadData %h, expected %h",
                                  $time, loadData, expected));
        end else begin
            assert (loadValid === 1'b0) else
                failRun($sformatf("MISMATCH at %0t ns: loadValid high with no load", $time));
        end
    endtask

    // One request per cycle; the previous cycle's result is checked first
    task automatic issueRequest(input logic valid, input logic [5:0] op, input logic [5:0] addr,
                                input logic [31:0] rt, input logic [31:0] st);
        logic [8:0]  immBits;
        logic [15:0] imm;
        @(posedge clk);
        #1;
        checkOutputs();
        immBits      = 9'(randomBits(9));
        imm          = {{7{immBits[8]}}, immBits};
        reqValid     = valid;
        instr.opcode = op;
        instr.rs     = 5'(randomBits(5));
        instr.rt     = 5'(randomBits(5));
        instr.imm    = imm;
        baseValue    = {26'b0, addr} - {{16{imm[15]}}, imm}; // Base plus offset lands on addr
        rtValue      = rt;
        storeValue   = st;
        if (valid && isStoreOpcode(op)) begin
            applyStore(op, addr, st);
        end
        if (valid && isLoadOpcode(op)) begin
            expectQ.push_back(expectedLoad(op, addr, rt));
        end
    endtask

    initial begin
        logic [5:0] addr;
        logic [5:0] lastAddr;
        logic [5:0] op;
        logic       valid;
        lfsrState   = 32'ha02;
        opcodeTable = '{opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr, opSb,
                        opSh, opSwl, opSw, opSwr, 6'h00, 6'h27, 6'h2c, 6'h3f};
        rst          = 1'b1;
        reqValid     = 1'b1; // A load held through reset must not raise loadValid
        instr        = '0;
        instr.opcode = opLw;
        baseValue    = '0;
        rtValue      = '0;
        storeValue   = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        assert (loadValid === 1'b0) else
            failRun($sformatf("MISMATCH at %0t ns: loadValid high during reset", $time));
        rst      = 1'b0;
        reqValid = 1'b0;

        // Fill every modeled word before any load
        for (int w = 0; w < 16; w++) begin
            issueRequest(1'b1, opSw, 6'(w * 4), randomBits(32), randomBits(32));
        end

        // Unsupported opcodes and idle load slots must not touch memory
        for (int i = 0; i < 16; i++) begin
            issueRequest(1'b1, opcodeTable[12 + (i % 4)], 6'(randomBits(6)),
                         randomBits(32), randomBits(32));
        end
        for (int i = 0; i < 4; i++) begin
            issueRequest(1'b0, opLw, 6'(randomBits(6)), randomBits(32), randomBits(32));
        end
        for (int w = 0; w < 16; w++) begin
            issueRequest(1'b1, opLw, 6'(w * 4), randomBits(32), randomBits(32));
        end

        for (int off = 0; off < 4; off++) begin
            addr = {4'(randomBits(4)), 2'(off)};
            issueRequest(1'b1, opSb, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLw, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opSh, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLw, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opSw, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLw, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLb, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLbu, addr, randomBits(32), randomBits(32));
            if (off % 2 == 0) begin
                issueRequest(1'b1, opLh, addr, randomBits(32), randomBits(32));
                issueRequest(1'b1, opLhu, addr, randomBits(32), randomBits(32));
            end
            issueRequest(1'b1, opLwl, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLwr, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opSwl, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLw, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opSwr, addr, randomBits(32), randomBits(32));
            issueRequest(1'b1, opLw, addr, randomBits(32), randomBits(32));
        end

        lastAddr = '0;
        for (int i = 0; i < numRandom; i++) begin
            op = opcodeTable[4'(randomBits(4))];
            if (randomBits(2) == 0) begin // Often hit the word just used
                addr = {lastAddr[5:2], 2'(randomBits(2))};
            end else begin
                addr = 6'(randomBits(6));
            end
            if (op == opLh || op == opLhu) begin
                addr[0] = 1'b0;
            end
            valid = (randomBits(3) != 0);
            issueRequest(valid, op, addr, randomBits(32), randomBits(32));
            lastAddr = addr;
        end

        issueRequest(1'b0, 6'h00, 6'h00, 32'h0, 32'h0);
        issueRequest(1'b0, 6'h00, 6'h00, 32'h0, 32'h0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- memAccess.f
+incdir+src
src/mipsInstrPkg.sv
src/memOpPkg.sv
src/MemInstrDecoder.sv
src/DataMemoryWriteShifter.sv
src/DataMemory.sv
src/DataMemoryReadShifter.sv
src/MemAccessUnit.sv
tests/memAccess_asserts.sv
tests/MemAccessUnitTb.sv

//--- Makefile
# Verilator build and run of the load/store path testbench

VERILATOR ?= verilator
TOP       ?= MemAccessUnitTb
BUILD_DIR ?= build
FILE_LIST ?= memAccess.f
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The binary exits with a failing status on any $fatal
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
